//--- rtl/regFileConfig.svh
/*
  Widths and counts for the VLIW integer register file.
  IDs with the top bit clear are general registers, so GPR_COUNT must be 2**GPR_INDEX_WIDTH.
*/
`ifndef REG_FILE_CONFIG_SVH
`define REG_FILE_CONFIG_SVH

`define REG_WIDTH        64 // Operand and result word
`define REG_ID_WIDTH     6
`define GPR_COUNT        32
`define GPR_INDEX_WIDTH  5
`define IMM_WIDTH        33 // Bit 32 carries the sign

// PC, GBR and LR are always full 48-bit addresses
`define ADDR_WIDTH       48
`define READ_PORTS       6

`endif

//--- rtl/regFilePkg.sv
/*
  Shared types of the register file. Special IDs sit in the upper half of the ID space.
  Struct fields are listed MSB first.
*/
`include "regFileConfig.svh"

package regFilePkg;

	// Special register IDs, everything with bit 5 clear is a GPR
	typedef enum logic [`REG_ID_WIDTH-1:0]
	{
		DLR = 6'h20,
		DHR = 6'h21,
		SP  = 6'h2F,
		PC  = 6'h30,
		GBR = 6'h31,
		LR  = 6'h32,
		IMM = 6'h3E, // Lane immediate
		ZZR = 6'h3F  // Zero register
	} regId_e;

	typedef struct packed
	{
		logic [`REG_ID_WIDTH-1:0] id;
		logic [`REG_WIDTH-1:0]    value;
	} wbLane_t;

	typedef struct packed
	{
		wbLane_t laneA;
		wbLane_t laneB;
		wbLane_t laneC;
	} wbStage_t;

	typedef struct packed
	{
		logic [`REG_ID_WIDTH-1:0] rs, rt, ru, rv, rx, ry;
	} readIds_t;

	typedef struct packed
	{
		logic [`REG_WIDTH-1:0] rs, rt, ru, rv, rx, ry;
	} readValues_t;

	typedef struct packed
	{
		logic [`IMM_WIDTH-1:0] immA, immB, immC;
	} immSet_t;

	typedef struct packed
	{
		logic [`ADDR_WIDTH-1:0] pc, gbr, lr;
	} ctrlRegs_t;

	typedef struct packed
	{
		logic [`REG_WIDTH-1:0] dlr, dhr, sp;
	} sideRegs_t;

endpackage

//--- rtl/laneBankFile.sv
/*
  Three GPR banks, one per write lane, plus a last-writer map per register.
  Same-index writes in one cycle resolve C over B over A. Bank contents have no reset.
*/
`include "regFileConfig.svh"

module laneBankFile
(
	input  logic                     clock,
	input  logic                     rstN,
	input  logic                     commit,
	input  regFilePkg::wbStage_t     wbEx3,
	input  regFilePkg::readIds_t     readIds,
	output regFilePkg::readValues_t  bankValues
);

	localparam int LANES = 3;

	regFilePkg::wbLane_t lanes [LANES]; // Index 0 is lane A

	logic [`REG_WIDTH-1:0] bank [LANES][`GPR_COUNT];
	logic [1:0]            lastWriter [`GPR_COUNT]; // Lane number that holds the live copy

	logic [`READ_PORTS-1:0][`REG_ID_WIDTH-1:0] portIds;
	logic [`READ_PORTS-1:0][`REG_WIDTH-1:0]    portVals;

	assign lanes = '{wbEx3.laneA, wbEx3.laneB, wbEx3.laneC};

	// Each lane owns its bank, so no write conflicts inside a bank
	always_ff @(posedge clock)
	begin
		for (int l = 0; l < LANES; l++)
		begin
			if (commit && !lanes[l].id[`REG_ID_WIDTH-1])
				bank[l][lanes[l].id[`GPR_INDEX_WIDTH-1:0]] <= lanes[l].value;
		end
	end

	// Later lanes overwrite earlier ones in the loop, giving C the last word
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int r = 0; r < `GPR_COUNT; r++)
				lastWriter[r] <= 2'd0; // Everything starts in bank A
		end
		else if (commit)
		begin
			for (int l = 0; l < LANES; l++)
			begin
				if (!lanes[l].id[`REG_ID_WIDTH-1])
					lastWriter[lanes[l].id[`GPR_INDEX_WIDTH-1:0]] <= 2'(l);
			end
		end
	end

	assign portIds = readIds; // rs lands in the top slot

	always_comb
	begin
		logic [`GPR_INDEX_WIDTH-1:0] idx;
		for (int p = 0; p < `READ_PORTS; p++)
		begin
			idx = portIds[p][`GPR_INDEX_WIDTH-1:0];
			portVals[p] = bank[lastWriter[idx]][idx];
		end
	end

	assign bankValues = portVals;

	// Code 3 names no bank
	for (genvar g = 0; g < `GPR_COUNT; g++)
	begin : mapCheck
		assert property (@(posedge clock) disable iff (!rstN) lastWriter[g] != 2'd3)
			else $error("last-writer map entry %0d holds an unused code", g);
	end

endmodule

//--- rtl/sideRegFile.sv
/*
  DLR, DHR and SP. A committed lane write wins over the external capture value.
  A blocked commit (hold or EX3 flush) freezes all three registers.
*/
`include "regFileConfig.svh"

module sideRegFile
(
	input  logic                   clock,
	input  logic                   rstN,
	input  logic                   commit,
	input  regFilePkg::wbStage_t   wbEx3,
	input  regFilePkg::sideRegs_t  sideIn,
	output regFilePkg::sideRegs_t  sideRegs
);

	// Highest lane targeting this register, else the external value
	function automatic logic [`REG_WIDTH-1:0] pickLane(
		input regFilePkg::regId_e     code,
		input regFilePkg::wbStage_t   wb,
		input logic [`REG_WIDTH-1:0]  fallback);
		logic [`REG_WIDTH-1:0] v;
		v = fallback;
		if (wb.laneA.id == code) v = wb.laneA.value;
		if (wb.laneB.id == code) v = wb.laneB.value;
		if (wb.laneC.id == code) v = wb.laneC.value;
		return v;
	endfunction

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			sideRegs <= '0;
		else if (commit)
		begin
			sideRegs.dlr <= pickLane(regFilePkg::DLR, wbEx3, sideIn.dlr);
			sideRegs.dhr <= pickLane(regFilePkg::DHR, wbEx3, sideIn.dhr);
			sideRegs.sp  <= pickLane(regFilePkg::SP,  wbEx3, sideIn.sp);
		end
	end

endmodule

//--- rtl/operandPort.sv
/*
  One combinational read port. Special IDs decode first, then EX1..EX3 results override.
  IMM and ZZR are never forwarded. Forwarding does not look at the EX3 flush.
*/
`include "regFileConfig.svh"

module operandPort
(
	input  logic                     clock,
	input  logic                     rstN,
	input  logic [`REG_ID_WIDTH-1:0] id,
	input  logic [`IMM_WIDTH-1:0]    imm,
	input  regFilePkg::ctrlRegs_t    ctrlRegs,
	input  regFilePkg::sideRegs_t    sideRegs,
	input  logic [`REG_WIDTH-1:0]    bankValue,
	input  regFilePkg::wbStage_t     wbEx1,
	input  regFilePkg::wbStage_t     wbEx2,
	input  regFilePkg::wbStage_t     wbEx3,
	output logic [`REG_WIDTH-1:0]    value
);

	localparam int ADDR_PAD = `REG_WIDTH - `ADDR_WIDTH;
	localparam int SIGN_PAD = `REG_WIDTH - (`IMM_WIDTH - 1);

	logic [`REG_WIDTH-1:0] decoded;
	logic                  noForward;

	always_comb
	begin
		case (id)
			regFilePkg::DLR: decoded = sideRegs.dlr;
			regFilePkg::DHR: decoded = sideRegs.dhr;
			regFilePkg::SP:  decoded = sideRegs.sp;
			regFilePkg::PC:  decoded = {{ADDR_PAD{1'b0}}, ctrlRegs.pc[`ADDR_WIDTH-1:1], 1'b0};
			regFilePkg::GBR: decoded = {{ADDR_PAD{1'b0}}, ctrlRegs.gbr};
			regFilePkg::LR:  decoded = {{ADDR_PAD{1'b0}}, ctrlRegs.lr};
			regFilePkg::IMM: decoded = {{SIGN_PAD{imm[`IMM_WIDTH-1]}}, imm[`IMM_WIDTH-2:0]};
			regFilePkg::ZZR: decoded = '0;
			default:         decoded = bankValue; // GPRs and unassigned upper IDs
		endcase
	end

	assign noForward = (id == regFilePkg::IMM) || (id == regFilePkg::ZZR);

	// Candidates from lowest to highest priority, so the last match wins
	always_comb
	begin
		regFilePkg::wbLane_t cand [9];
		cand = '{wbEx3.laneC, wbEx3.laneB, wbEx3.laneA,
			wbEx2.laneC, wbEx2.laneB, wbEx2.laneA,
			wbEx1.laneC, wbEx1.laneB, wbEx1.laneA};
		value = decoded;
		for (int i = 0; i < 9; i++)
		begin
			if (!noForward && (cand[i].id == id))
				value = cand[i].value;
		end
	end

	// Zero register must survive any matching write-back
	assert property (@(posedge clock) disable iff (!rstN)
		(id == regFilePkg::ZZR) |-> (value == '0))
		else $error("ZZR read returned a nonzero value");

endmodule

//--- rtl/regFileTop.sv
/*
  Integer register file, six read ports and three write lanes committing at EX3.
  Reads are combinational. A commit needs hold and ex3Flush both low.
*/
`include "regFileConfig.svh"

module regFileTop
(
	input  logic                     clock,
	input  logic                     rstN,
	input  regFilePkg::readIds_t     readIds,
	input  regFilePkg::immSet_t      imms,
	input  regFilePkg::ctrlRegs_t    ctrlRegs,
	input  regFilePkg::sideRegs_t    sideIn,
	input  regFilePkg::wbStage_t     wbEx1,
	input  regFilePkg::wbStage_t     wbEx2,
	input  regFilePkg::wbStage_t     wbEx3,
	input  logic                     ex3Flush,
	input  logic                     hold,
	output regFilePkg::readValues_t  readValues,
	output regFilePkg::sideRegs_t    sideOut
);

	logic                    commit;
	regFilePkg::readValues_t bankValues;

	assign commit = !hold && !ex3Flush;

	laneBankFile banks0 (.clock, .rstN, .commit, .wbEx3, .readIds, .bankValues);

	sideRegFile side0 (.clock, .rstN, .commit, .wbEx3, .sideIn, .sideRegs(sideOut));

	// Lane A ports
	operandPort portRs (.clock, .rstN, .id(readIds.rs), .imm(imms.immA),
		.ctrlRegs, .sideRegs(sideOut), .bankValue(bankValues.rs),
		.wbEx1, .wbEx2, .wbEx3, .value(readValues.rs));

	operandPort portRt (.clock, .rstN, .id(readIds.rt), .imm(imms.immA),
		.ctrlRegs, .sideRegs(sideOut), .bankValue(bankValues.rt),
		.wbEx1, .wbEx2, .wbEx3, .value(readValues.rt));

	// Lane B ports
	operandPort portRu (.clock, .rstN, .id(readIds.ru), .imm(imms.immB),
		.ctrlRegs, .sideRegs(sideOut), .bankValue(bankValues.ru),
		.wbEx1, .wbEx2, .wbEx3, .value(readValues.ru));

	operandPort portRv (.clock, .rstN, .id(readIds.rv), .imm(imms.immB),
		.ctrlRegs, .sideRegs(sideOut), .bankValue(bankValues.rv),
		.wbEx1, .wbEx2, .wbEx3, .value(readValues.rv));

	// Lane C ports
	operandPort portRx (.clock, .rstN, .id(readIds.rx), .imm(imms.immC),
		.ctrlRegs, .sideRegs(sideOut), .bankValue(bankValues.rx),
		.wbEx1, .wbEx2, .wbEx3, .value(readValues.rx));

	operandPort portRy (.clock, .rstN, .id(readIds.ry), .imm(imms.immC),
		.ctrlRegs, .sideRegs(sideOut), .bankValue(bankValues.ry),
		.wbEx1, .wbEx2, .wbEx3, .value(readValues.ry));

endmodule

//--- dv/regFileTb.sv
/*
  Testbench for regFileTop. Inputs change on the rising edge, outputs are compared at the falling one.
  Every GPR is preloaded first because the banks have no reset value.
*/
`include "regFileConfig.svh"

module regFileTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [`REG_ID_WIDTH-1:0] IDLE_ID = 6'h3A; // Unassigned upper ID, never read
	localparam int CHECK_LIMIT = 6; // ns to wait for the compare process

	logic                    clock;
	logic                    rstN;
	regFilePkg::readIds_t    readIds;
	regFilePkg::immSet_t     imms;
	regFilePkg::ctrlRegs_t   ctrlRegs;
	regFilePkg::sideRegs_t   sideIn;
	regFilePkg::wbStage_t    wbEx1, wbEx2, wbEx3;
	logic                    ex3Flush;
	logic                    hold;
	regFilePkg::readValues_t readValues;
	regFilePkg::sideRegs_t   sideOut;

	logic [`REG_WIDTH-1:0] gprModel [`GPR_COUNT];
	regFilePkg::sideRegs_t sideModel;

	string testName = "reset";
	int    checkSeq = 0;
	int    doneSeq = 0;
	int    testErrors = 0;
	int    testChecks = 0;
	int    totalErrors = 0;
	int    totalChecks = 0;
	int    testCount = 0;
	event  checkTimeout;

	regFileTop dut0 (.clock, .rstN, .readIds, .imms, .ctrlRegs, .sideIn, .wbEx1, .wbEx2,
		.wbEx3, .ex3Flush, .hold, .readValues, .sideOut);

	always #4 clock = ~clock;

	function automatic regFilePkg::wbLane_t makeLane(input logic [`REG_ID_WIDTH-1:0] id,
		input logic [`REG_WIDTH-1:0] value);
		return {id, value};
	endfunction

	function automatic logic [`REG_WIDTH-1:0] rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic logic [`IMM_WIDTH-1:0] randImm();
		return {1'($urandom), $urandom};
	endfunction

	// Mirror of the committed state, same edge as the DUT
	always @(posedge clock or negedge rstN)
	begin
		regFilePkg::wbLane_t lanes [3];
		if (!rstN)
			sideModel = '0;
		else if (!hold && !ex3Flush)
		begin
			lanes = '{wbEx3.laneA, wbEx3.laneB, wbEx3.laneC};
			sideModel = sideIn; // Captured unless a lane writes
			for (int l = 0; l < 3; l++) // Later lane overrides, so C wins
			begin
				if (!lanes[l].id[`REG_ID_WIDTH-1])
					gprModel[lanes[l].id[`GPR_INDEX_WIDTH-1:0]] = lanes[l].value;
				case (lanes[l].id)
					regFilePkg::DLR: sideModel.dlr = lanes[l].value;
					regFilePkg::DHR: sideModel.dhr = lanes[l].value;
					regFilePkg::SP:  sideModel.sp = lanes[l].value;
					default: ;
				endcase
			end
		end
	end

	// Expected read value, forwarding candidates listed from highest priority
	function automatic logic [`REG_WIDTH-1:0] expectedOperand(
		input logic [`REG_ID_WIDTH-1:0] id,
		input logic [`IMM_WIDTH-1:0] imm);
		regFilePkg::wbLane_t order [9];
		order = '{wbEx1.laneA, wbEx1.laneB, wbEx1.laneC, wbEx2.laneA, wbEx2.laneB,
			wbEx2.laneC, wbEx3.laneA, wbEx3.laneB, wbEx3.laneC};
		if (id == regFilePkg::IMM)
			return {{32{imm[32]}}, imm[31:0]};
		if (id == regFilePkg::ZZR)
			return '0;
		for (int i = 0; i < 9; i++)
		begin
			if (order[i].id == id)
				return order[i].value;
		end
		case (id)
			regFilePkg::DLR: return sideModel.dlr;
			regFilePkg::DHR: return sideModel.dhr;
			regFilePkg::SP:  return sideModel.sp;
			regFilePkg::PC:  return {16'h0, ctrlRegs.pc[47:1], 1'b0};
			regFilePkg::GBR: return {16'h0, ctrlRegs.gbr};
			regFilePkg::LR:  return {16'h0, ctrlRegs.lr};
			default:         return gprModel[id[`GPR_INDEX_WIDTH-1:0]];
		endcase
	endfunction

	task automatic checkPort(input string port, input logic [`REG_ID_WIDTH-1:0] id,
		input logic [`IMM_WIDTH-1:0] imm, input logic [`REG_WIDTH-1:0] actual);
		logic [`REG_WIDTH-1:0] expected;
		expected = expectedOperand(id, imm);
		testChecks++;
		if (actual !== expected)
		begin
			$display("ERR %s port %s id %h: expected %h actual %h",
				testName, port, id, expected, actual);
			testErrors++;
		end
	endtask

	// Compare at the falling edge, once per requested check
	always @(negedge clock)
	begin
		if (rstN && doneSeq != checkSeq)
		begin
			checkPort("rs", readIds.rs, imms.immA, readValues.rs);
			checkPort("rt", readIds.rt, imms.immA, readValues.rt);
			checkPort("ru", readIds.ru, imms.immB, readValues.ru);
			checkPort("rv", readIds.rv, imms.immB, readValues.rv);
			checkPort("rx", readIds.rx, imms.immC, readValues.rx);
			checkPort("ry", readIds.ry, imms.immC, readValues.ry);
			testChecks++;
			if (sideOut !== sideModel)
			begin
				$display("ERR %s sideOut: expected %h actual %h", testName, sideModel, sideOut);
				testErrors++;
			end
			doneSeq = checkSeq;
		end
	end

	initial
	begin
		@(checkTimeout);
		$display("timeout: compare process gave no answer in test %s", testName);
		$display(">>> FAIL");
		$finish;
	end

	task automatic checkNow();
		int waited;
		waited = 0;
		checkSeq++;
		while (doneSeq != checkSeq && waited < CHECK_LIMIT)
		begin
			#1;
			waited++;
		end
		if (doneSeq != checkSeq)
			-> checkTimeout;
	endtask

	// Default drive for one cycle, tests override fields afterwards
	task automatic startCycle(input regFilePkg::readIds_t ids);
		@(posedge clock);
		readIds <= ids;
		imms <= {randImm(), randImm(), randImm()};
		ctrlRegs <= {48'(rand64()), 48'(rand64()), 48'(rand64())};
		sideIn <= {rand64(), rand64(), rand64()};
		wbEx1 <= {3{makeLane(IDLE_ID, '0)}};
		wbEx2 <= {3{makeLane(IDLE_ID, '0)}};
		wbEx3 <= {3{makeLane(IDLE_ID, '0)}};
		hold <= 1'b0;
		ex3Flush <= 1'b0;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrors = 0;
		testChecks = 0;
	endtask

	task automatic finishTest();
		$display("test %-16s %0d checks, %0d errors", testName, testChecks, testErrors);
		totalErrors += testErrors;
		totalChecks += testChecks;
		testCount++;
	endtask

	task automatic preloadAll();
		beginTest("preload");
		for (int r = 0; r < `GPR_COUNT; r += 3)
		begin
			startCycle({6{regFilePkg::ZZR}});
			wbEx3 <= {makeLane(6'(r), rand64()), makeLane(6'((r + 1) % 32), rand64()),
				makeLane(6'((r + 2) % 32), rand64())};
			checkNow();
		end
		finishTest();
	endtask

	task automatic commitReadback();
		int base;
		logic [`REG_ID_WIDTH-1:0] r0, r1, r2;
		beginTest("commitReadback");
		for (int n = 0; n < 8; n++)
		begin
			base = $urandom % 32;
			r0 = 6'(base);
			r1 = 6'((base + 11) % 32);
			r2 = 6'((base + 22) % 32);
			startCycle({r0, r1, r2, r0, r1, r2}); // Seen through EX3 forwarding
			wbEx3 <= {makeLane(r0, rand64()), makeLane(r1, rand64()), makeLane(r2, rand64())};
			checkNow();
			startCycle({6{regFilePkg::ZZR}}); // Idle cycle
			checkNow();
			startCycle({r2, r1, r0, r2, r1, r0});
			checkNow();
		end
		finishTest();
	endtask

	task automatic lanePriority();
		logic [`REG_ID_WIDTH-1:0] r;
		beginTest("lanePriority");
		for (int n = 0; n < 3; n++) // All three, then A with C, then A with B
		begin
			r = 6'($urandom % 32);
			startCycle({6{regFilePkg::ZZR}});
			wbEx3 <= {makeLane(r, rand64()), makeLane((n == 1) ? IDLE_ID : r, rand64()),
				makeLane((n == 2) ? IDLE_ID : r, rand64())};
			checkNow();
			startCycle({6{r}});
			checkNow();
		end
		finishTest();
	endtask

	task automatic blockedCommits();
		logic [`REG_ID_WIDTH-1:0] r;
		beginTest("blockedCommits");
		for (int n = 0; n < 3; n++) // Hold, flush, then open with idle lanes
		begin
			r = 6'($urandom % 32);
			startCycle({r, {5{regFilePkg::ZZR}}});
			hold <= (n == 0);
			ex3Flush <= (n == 1);
			if (n != 2)
				wbEx3 <= {makeLane(r, rand64()), makeLane(regFilePkg::DLR, rand64()),
					makeLane(regFilePkg::SP, rand64())};
			checkNow();
			startCycle({r, regFilePkg::DLR, regFilePkg::DHR, regFilePkg::SP, r, regFilePkg::ZZR});
			checkNow();
		end
		finishTest();
	endtask

	task automatic forwardingOrder();
		logic [`REG_ID_WIDTH-1:0] r, fid;
		regFilePkg::wbLane_t order [9];
		beginTest("forwardingOrder");
		for (int k = 0; k < 9; k++) // Slot k is the first lane carrying r
		begin
			r = 6'($urandom % 32);
			for (int i = 0; i < 9; i++)
			begin
				if (i >= k)
					fid = r;
				else if (i % 2)
					fid = regFilePkg::ZZR;
				else
					fid = regFilePkg::IMM;
				order[i] = makeLane(fid, rand64());
			end
			startCycle({r, regFilePkg::IMM, r, regFilePkg::ZZR, r, regFilePkg::IMM});
			wbEx1 <= {order[0], order[1], order[2]};
			wbEx2 <= {order[3], order[4], order[5]};
			wbEx3 <= {order[6], order[7], order[8]};
			checkNow();
		end
		finishTest();
	endtask

	task automatic specialIds();
		beginTest("specialIds");
		for (int n = 0; n < 2; n++)
		begin
			startCycle({6{regFilePkg::ZZR}});
			wbEx3 <= {makeLane(regFilePkg::DLR, rand64()), makeLane(regFilePkg::DHR, rand64()),
				makeLane(regFilePkg::SP, rand64())};
			checkNow();
			startCycle({regFilePkg::DLR, regFilePkg::IMM, regFilePkg::IMM, regFilePkg::DHR,
				regFilePkg::SP, regFilePkg::IMM});
			imms.immA[32] <= n[0]; // Opposite signs on lanes A and B
			imms.immB[32] <= !n[0];
			checkNow();
			startCycle({regFilePkg::ZZR, regFilePkg::PC, regFilePkg::GBR, regFilePkg::LR,
				regFilePkg::ZZR, regFilePkg::PC});
			ctrlRegs.pc[0] <= 1'b1;
			ctrlRegs.gbr[`ADDR_WIDTH-1] <= 1'b1; // Top bit set so the extension shows
			ctrlRegs.lr[`ADDR_WIDTH-1] <= 1'b1;
			checkNow();
		end
		finishTest();
	endtask

	initial
	begin
		void'($urandom(32'h49ce0168));
		clock = 1'b0;
		rstN = 1'b0;
		readIds = {6{regFilePkg::ZZR}};
		imms = '0;
		ctrlRegs = '0;
		sideIn = '0;
		wbEx1 = {3{makeLane(IDLE_ID, '0)}};
		wbEx2 = {3{makeLane(IDLE_ID, '0)}};
		wbEx3 = {3{makeLane(IDLE_ID, '0)}};
		ex3Flush = 1'b0;
		hold = 1'b0;
		repeat (8) @(posedge clock);
		rstN <= 1'b1;
		preloadAll();
		commitReadback();
		lanePriority();
		blockedCommits();
		forwardingOrder();
		specialIds();
		$display("tests %0d, checks %0d, errors %0d", testCount, totalChecks, totalErrors);
		if (totalErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- list.f
+incdir+rtl
rtl/regFilePkg.sv
rtl/laneBankFile.sv
rtl/sideRegFile.sv
rtl/operandPort.sv
rtl/regFileTop.sv
dv/regFileTb.sv

//--- Bender.yml
package:
  name: regFile

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/regFilePkg.sv
      - rtl/laneBankFile.sv
      - rtl/sideRegFile.sv
      - rtl/operandPort.sv
      - rtl/regFileTop.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/regFileTb.sv
